/* arc4_crack_macros.svh */
`ifndef ARC4_CRACK_MACROS_SVH
`define ARC4_CRACK_MACROS_SVH

// every memory holds one length-prefixed message or the full S table
`define ARC4_MEM_DEPTH 256

// accepted plaintext range, inclusive
`define PRINT_LO 8'h20
`define PRINT_HI 8'h7E

// wishbone byte addresses on the 12-bit bus
`define REG_CTRL      12'h000
`define REG_STATUS    12'h004
`define REG_FIRST_KEY 12'h008
`define REG_LAST_KEY  12'h00C
`define REG_FOUND_KEY 12'h010
`define CT_BASE       12'h400
`define PT_BASE       12'h800

`endif

/* arc4_crack_pkg.sv */
`default_nettype none

package arc4_crack_pkg;

	// candidate key, key byte 0 sits in bits 23..16
	typedef logic [23:0] key_t;
	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  mem_addr_t;

	typedef enum logic [3:0] {
		a4_idle, a4_init_s, a4_ksa_rd_i, a4_ksa_rd_j, a4_ksa_swap,
		a4_prga_rd_len, a4_prga_rd_i, a4_prga_rd_j, a4_prga_swap,
		a4_prga_rd_k, a4_prga_write, a4_done
	} arc4_state_e;

	typedef enum logic [2:0] {
		ck_idle, ck_rd_len, ck_ld_addr, ck_test, ck_valid
	} check_state_e;

	typedef enum logic [2:0] {
		cr_idle, cr_start_arc4, cr_wait_arc4, cr_start_check,
		cr_wait_check, cr_decide, cr_found, cr_exhausted
	} crack_state_e;

endpackage

`default_nettype wire

/* byte_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arc4_crack_macros.svh"

module byte_ram
	import arc4_crack_pkg::*;
(
	input  wire            clk,
	input  wire mem_addr_t addr,
	input  wire byte_t     wdata,
	input  wire            we,
	output byte_t          rdata
);

	byte_t mem [0:`ARC4_MEM_DEPTH-1];

	// a read in the same cycle as a write returns the old byte
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

/* arc4_core.sv */
`timescale 1ns/1ps
`default_nettype none

module arc4_core
	import arc4_crack_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,
	input  wire            en,
	output logic           rdy,
	input  wire key_t      key,
	output mem_addr_t      ct_addr,
	input  wire byte_t     ct_rddata,
	output mem_addr_t      pt_addr,
	output byte_t          pt_wrdata,
	output logic           pt_wren,
	input  wire byte_t     pt_rddata
);

	arc4_state_e state;
	mem_addr_t   i, j, j_next, s_addr;
	byte_t       si, sj, k, key_byte, s_wdata, s_rdata;
	logic [1:0]  kidx;
	logic        phase;
	logic        s_we;

	byte_ram u_s_ram (
		.clk   (clk),
		.addr  (s_addr),
		.wdata (s_wdata),
		.we    (s_we),
		.rdata (s_rdata)
	);

	// key byte for i mod 3, tracked by kidx instead of a divider
	always_comb begin
		case (kidx)
			2'd0:    key_byte = key[23:16];
			2'd1:    key_byte = key[15:8];
			default: key_byte = key[7:0];
		endcase
	end

	assign j_next = (state == a4_ksa_rd_j) ? j + s_rdata + key_byte : j + s_rdata;

	always_comb begin
		rdy       = 1'b0;
		s_addr    = i;
		s_wdata   = i;
		s_we      = 1'b0;
		ct_addr   = '0;
		pt_addr   = '0;
		pt_wrdata = ct_rddata ^ s_rdata;
		pt_wren   = 1'b0;
		case (state)
			a4_idle:   rdy = 1'b1;
			a4_init_s: s_we = 1'b1;
			a4_ksa_rd_j, a4_prga_rd_j: s_addr = j_next;
			// single-port S, so the swap takes two write cycles
			a4_ksa_swap, a4_prga_swap: begin
				s_we = 1'b1;
				if (phase) begin
					s_addr  = j;
					s_wdata = si;
				end else begin
					s_addr  = i;
					s_wdata = s_rdata;
				end
			end
			a4_prga_rd_len: begin
				if (phase) begin
					pt_wrdata = ct_rddata;
					pt_wren   = 1'b1;
				end
			end
			a4_prga_rd_i: s_addr = i + 8'd1;
			a4_prga_rd_k: begin
				s_addr  = si + sj;
				ct_addr = k;
			end
			a4_prga_write: begin
				pt_addr = k;
				pt_wren = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= a4_idle;
			i     <= '0;
			j     <= '0;
			si    <= '0;
			sj    <= '0;
			k     <= '0;
			kidx  <= '0;
			phase <= 1'b0;
		end else begin
			case (state)
				a4_idle: begin
					if (en) begin
						i     <= '0;
						state <= a4_init_s;
					end
				end
				a4_init_s: begin
					i <= i + 8'd1;
					if (i == 8'hFF) begin
						j     <= '0;
						kidx  <= '0;
						state <= a4_ksa_rd_i;
					end
				end
				a4_ksa_rd_i: state <= a4_ksa_rd_j;
				a4_ksa_rd_j, a4_prga_rd_j: begin
					si    <= s_rdata;
					j     <= j_next;
					state <= (state == a4_ksa_rd_j) ? a4_ksa_swap : a4_prga_swap;
				end
				a4_ksa_swap: begin
					phase <= ~phase;
					if (!phase) begin
						sj <= s_rdata;
					end else begin
						i    <= i + 8'd1;
						kidx <= (kidx == 2'd2) ? 2'd0 : kidx + 2'd1;
						if (i == 8'hFF) begin
							j     <= '0;
							state <= a4_prga_rd_len;
						end else begin
							state <= a4_ksa_rd_i;
						end
					end
				end
				// phase 0 reads ct[0], phase 1 copies it to pt[0]
				a4_prga_rd_len: begin
					phase <= ~phase;
					if (phase) begin
						k     <= 8'd1;
						state <= (ct_rddata == 8'd0) ? a4_done : a4_prga_rd_i;
					end
				end
				a4_prga_rd_i: begin
					i     <= i + 8'd1;
					state <= a4_prga_rd_j;
				end
				a4_prga_swap: begin
					phase <= ~phase;
					if (!phase)
						sj <= s_rdata;
					else
						state <= a4_prga_rd_k;
				end
				a4_prga_rd_k: state <= a4_prga_write;
				// pt address was 0 in rd_k, so pt_rddata holds the message length here
				a4_prga_write: begin
					k     <= k + 8'd1;
					state <= (k == pt_rddata) ? a4_done : a4_prga_rd_i;
				end
				a4_done: state <= a4_idle;
				default: state <= a4_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* pt_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arc4_crack_macros.svh"

module pt_check
	import arc4_crack_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        en,
	output logic       rdy,
	output mem_addr_t  addr,
	input  wire byte_t rd_data,
	output logic       key_valid
);

	check_state_e state;
	byte_t        len;
	mem_addr_t    idx;
	logic         printable;

	assign printable = (rd_data >= `PRINT_LO) && (rd_data <= `PRINT_HI);

	// address stays at 0 while ready so an en cycle already fetches the length
	always_comb begin
		rdy       = (state == ck_idle) || (state == ck_valid);
		key_valid = (state == ck_valid);
		addr      = (state == ck_ld_addr) ? idx : '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ck_idle;
			len   <= '0;
			idx   <= '0;
		end else begin
			case (state)
				ck_idle, ck_valid: begin
					if (en)
						state <= ck_rd_len;
				end
				ck_rd_len: begin
					len   <= rd_data;
					idx   <= 8'd1;
					state <= (rd_data == 8'd0) ? ck_valid : ck_ld_addr;
				end
				ck_ld_addr: state <= ck_test;
				// first byte outside the range ends the scan with a reject
				ck_test: begin
					if (!printable) begin
						state <= ck_idle;
					end else if (idx == len) begin
						state <= ck_valid;
					end else begin
						idx   <= idx + 8'd1;
						state <= ck_ld_addr;
					end
				end
				default: state <= ck_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* crack_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module crack_ctrl
	import arc4_crack_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,
	input  wire            start,
	input  wire            abort,
	input  wire key_t      first_key,
	input  wire key_t      last_key,
	output logic           busy,
	output logic           done,
	output logic           found,
	output key_t           found_key,
	output mem_addr_t      ct_addr,
	input  wire byte_t     ct_rddata,
	input  wire mem_addr_t pt_rd_addr,
	output byte_t          pt_rd_data
);

	crack_state_e state;
	key_t         cand;
	logic         a4_en, a4_rdy, a4_pt_wren, chk_en, chk_rdy, key_valid, pt_we;
	mem_addr_t    a4_pt_addr, chk_addr, pt_addr;
	byte_t        a4_pt_wrdata, pt_rdata;

	arc4_core u_arc4 (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (a4_en),
		.rdy       (a4_rdy),
		.key       (cand),
		.ct_addr   (ct_addr),
		.ct_rddata (ct_rddata),
		.pt_addr   (a4_pt_addr),
		.pt_wrdata (a4_pt_wrdata),
		.pt_wren   (a4_pt_wren),
		.pt_rddata (pt_rdata)
	);

	pt_check u_check (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (chk_en),
		.rdy       (chk_rdy),
		.addr      (chk_addr),
		.rd_data   (pt_rdata),
		.key_valid (key_valid)
	);

	byte_ram u_pt_ram (
		.clk   (clk),
		.addr  (pt_addr),
		.wdata (a4_pt_wrdata),
		.we    (pt_we),
		.rdata (pt_rdata)
	);

	assign busy       = !(state inside {cr_idle, cr_found, cr_exhausted});
	assign found      = (state == cr_found);
	assign a4_en      = (state == cr_start_arc4) && a4_rdy;
	assign chk_en     = (state == cr_start_check) && chk_rdy;
	assign pt_rd_data = pt_rdata;

	// the bus window owns the plaintext memory whenever no search runs
	always_comb begin
		pt_addr = pt_rd_addr;
		pt_we   = 1'b0;
		case (state)
			cr_start_arc4, cr_wait_arc4: begin
				pt_addr = a4_pt_addr;
				pt_we   = a4_pt_wren;
			end
			cr_start_check, cr_wait_check, cr_decide: pt_addr = chk_addr;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= cr_idle;
			cand      <= '0;
			found_key <= '0;
			done      <= 1'b0;
		end else begin
			case (state)
				cr_idle, cr_found, cr_exhausted: begin
					if (start) begin
						cand  <= first_key;
						done  <= 1'b0;
						state <= cr_start_arc4;
					end
				end
				cr_start_arc4:  if (a4_rdy) state <= cr_wait_arc4;
				cr_wait_arc4:   if (a4_rdy) state <= cr_start_check;
				cr_start_check: if (chk_rdy) state <= cr_wait_check;
				cr_wait_check:  if (chk_rdy) state <= cr_decide;
				// a first key above the last key stops after one candidate
				cr_decide: begin
					if (key_valid) begin
						found_key <= cand;
						done      <= 1'b1;
						state     <= cr_found;
					end else if (cand >= last_key) begin
						done  <= 1'b1;
						state <= cr_exhausted;
					end else begin
						cand  <= cand + 24'd1;
						state <= cr_start_arc4;
					end
				end
				default: state <= cr_idle;
			endcase
			if (abort && busy) begin
				done  <= 1'b1;
				state <= cr_idle;
			end
		end
	end

endmodule

`default_nettype wire

/* crack_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arc4_crack_macros.svh"

module crack_regs
	import arc4_crack_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,
	input  wire            wb_cyc,
	input  wire            wb_stb,
	input  wire            wb_we,
	input  wire [11:0]     wb_adr,
	input  wire [31:0]     wb_dat_w,
	input  wire [3:0]      wb_sel,
	output logic [31:0]    wb_dat_r,
	output logic           wb_ack,
	output logic           start,
	output logic           abort,
	output key_t           first_key,
	output key_t           last_key,
	input  wire            busy,
	input  wire            done,
	input  wire            found,
	input  wire key_t      found_key,
	output mem_addr_t      pt_rd_addr,
	input  wire byte_t     pt_rd_data,
	input  wire mem_addr_t ct_addr,
	output byte_t          ct_rddata
);

	logic        req, is_ct, is_pt, pt_wait, ct_we;
	logic [31:0] reg_rdata;
	mem_addr_t   ct_ram_addr;

	function automatic key_t write_lanes(key_t cur);
		key_t nxt;
		nxt = cur;
		if (wb_sel[0])
			nxt[7:0] = wb_dat_w[7:0];
		if (wb_sel[1])
			nxt[15:8] = wb_dat_w[15:8];
		if (wb_sel[2])
			nxt[23:16] = wb_dat_w[23:16];
		return nxt;
	endfunction

	// new request only when no ack is out and no window read is pending
	assign req   = wb_cyc && wb_stb && !wb_ack && !pt_wait;
	assign is_ct = ({wb_adr[11:10], 10'd0} == `CT_BASE);
	assign is_pt = ({wb_adr[11:10], 10'd0} == `PT_BASE);

	// window reads are issued straight from the bus address
	assign pt_rd_addr = wb_adr[9:2];

	// the engine owns the ciphertext port during a search
	assign ct_ram_addr = busy ? ct_addr : wb_adr[9:2];
	assign ct_we       = wb_ack && wb_we && is_ct && wb_sel[0] && !busy;

	byte_ram u_ct_ram (
		.clk   (clk),
		.addr  (ct_ram_addr),
		.wdata (wb_dat_w[7:0]),
		.we    (ct_we),
		.rdata (ct_rddata)
	);

	always_comb begin
		case (wb_adr)
			`REG_STATUS:    reg_rdata = {29'd0, found, done, busy};
			`REG_FIRST_KEY: reg_rdata = {8'd0, first_key};
			`REG_LAST_KEY:  reg_rdata = {8'd0, last_key};
			`REG_FOUND_KEY: reg_rdata = {8'd0, found_key};
			default:        reg_rdata = 32'd0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack    <= 1'b0;
			pt_wait   <= 1'b0;
			start     <= 1'b0;
			abort     <= 1'b0;
			first_key <= '0;
			last_key  <= '0;
		end else begin
			wb_ack <= 1'b0;
			start  <= 1'b0;
			abort  <= 1'b0;
			if (pt_wait) begin
				pt_wait <= 1'b0;
				wb_ack  <= 1'b1;
			end else if (req) begin
				if (is_pt && !wb_we)
					pt_wait <= 1'b1;
				else
					wb_ack <= 1'b1;
				if (wb_we && wb_sel[0] && wb_adr == `REG_CTRL) begin
					start <= wb_dat_w[0];
					abort <= wb_dat_w[1];
				end
				// key changes during a search are dropped but still acked
				if (wb_we && !busy && wb_adr == `REG_FIRST_KEY)
					first_key <= write_lanes(first_key);
				if (wb_we && !busy && wb_adr == `REG_LAST_KEY)
					last_key <= write_lanes(last_key);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pt_wait)
			wb_dat_r <= {24'd0, pt_rd_data};
		else if (req)
			wb_dat_r <= reg_rdata;
	end

endmodule

`default_nettype wire

/* arc4_crack_top.sv */
`timescale 1ns/1ps
`default_nettype none

module arc4_crack_top
	import arc4_crack_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire         wb_cyc,
	input  wire         wb_stb,
	input  wire         wb_we,
	input  wire [11:0]  wb_adr,
	input  wire [31:0]  wb_dat_w,
	input  wire [3:0]   wb_sel,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack
);

	logic      start, abort, busy, done, found;
	key_t      first_key, last_key, found_key;
	mem_addr_t pt_rd_addr, ct_addr;
	byte_t     pt_rd_data, ct_rddata;

	crack_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_sel     (wb_sel),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.start      (start),
		.abort      (abort),
		.first_key  (first_key),
		.last_key   (last_key),
		.busy       (busy),
		.done       (done),
		.found      (found),
		.found_key  (found_key),
		.pt_rd_addr (pt_rd_addr),
		.pt_rd_data (pt_rd_data),
		.ct_addr    (ct_addr),
		.ct_rddata  (ct_rddata)
	);

	crack_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.abort      (abort),
		.first_key  (first_key),
		.last_key   (last_key),
		.busy       (busy),
		.done       (done),
		.found      (found),
		.found_key  (found_key),
		.ct_addr    (ct_addr),
		.ct_rddata  (ct_rddata),
		.pt_rd_addr (pt_rd_addr),
		.pt_rd_data (pt_rd_data)
	);

endmodule

`default_nettype wire

/* arc4_crack_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module arc4_crack_properties (
	input wire clk,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input wire start,
	input wire busy,
	input wire done
);

	// one ack per request, never stretched
	ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else $error("wb_ack was high for two cycles in a row");

	// the master holds its request until ack, so the request is seen before and with ack
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb) && wb_cyc && wb_stb)
		else $error("wb_ack without a bus request");

	done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(done && busy))
		else $error("done and busy were high together");

	// busy only rises from a start pulse
	busy_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
		!busy && !start |=> !busy)
		else $error("busy rose without a start pulse");

endmodule

bind arc4_crack_top arc4_crack_properties u_props (
	.clk    (clk),
	.rst_n  (rst_n),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.start  (start),
	.busy   (busy),
	.done   (done)
);

`default_nettype wire

/* arc4_crack_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "arc4_crack_macros.svh"

module arc4_crack_tb
	import arc4_crack_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int N_SUCCESS    = 4;
	localparam int N_RUNS       = N_SUCCESS + 3;
	localparam int MAX_KEYS     = 8;
	localparam int MAX_LEN      = 40;
	// each key costs the S fill, the key schedule and about 8 cycles per message byte
	localparam int LIMIT_CYCLES = N_RUNS * (MAX_KEYS * (1400 + 8 * MAX_LEN) + 2000);

	logic        clk, rst_n, wb_cyc, wb_stb, wb_we, wb_ack;
	logic [11:0] wb_adr;
	logic [31:0] wb_dat_w, wb_dat_r;
	logic [3:0]  wb_sel;

	integer seed = 32'he4e7_63b6;
	int     msg_len;
	byte_t  msg [0:255];
	byte_t  ct [0:255];
	byte_t  ks [0:255];
	byte_t  s_box [0:255];
	key_t   secret, exp_key;
	logic   exp_found;

	arc4_crack_top DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_sel   (wb_sel),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: the searches did not finish within %0d cycles", LIMIT_CYCLES);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("=== FAIL ===");
			$fatal(1, "stopping at the first error");
		end
	endtask

	// outputs are sampled on the falling edge, the request drops on the next rising edge
	task automatic wait_ack(output logic [31:0] data);
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		data = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic bus_write(input logic [11:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_w <= data;
		wb_sel   <= 4'hF;
		wait_ack(unused);
	endtask

	task automatic bus_read(input logic [11:0] adr, output logic [31:0] data);
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b0;
		wb_adr   <= adr;
		wb_dat_w <= 32'd0;
		wb_sel   <= 4'hF;
		wait_ack(data);
	endtask

	// reference ARC4 that leaves the keystream for message bytes 1..len in ks
	task automatic make_keystream(input key_t key, input int len);
		byte_t      tmp, key_byte;
		logic [7:0] i, j;
		for (int n = 0; n < 256; n++)
			s_box[n] = 8'(n);
		j = 8'd0;
		for (int n = 0; n < 256; n++) begin
			key_byte = 8'(key >> (16 - 8 * (n % 3)));
			j = j + s_box[n] + key_byte;
			tmp = s_box[n];
			s_box[n] = s_box[j];
			s_box[j] = tmp;
		end
		i = 8'd0;
		j = 8'd0;
		for (int k = 1; k <= len; k++) begin
			i = i + 8'd1;
			j = j + s_box[i];
			tmp = s_box[i];
			s_box[i] = s_box[j];
			s_box[j] = tmp;
			ks[k] = s_box[8'(s_box[i] + s_box[j])];
		end
	endtask

	function automatic logic text_printable(input int len);
		byte_t b;
		for (int k = 1; k <= len; k++) begin
			b = ct[k] ^ ks[k];
			if (b < `PRINT_LO || b > `PRINT_HI)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// walks the range upward and stops at the first accepted key or at the last key
	task automatic model_search(input key_t first, input key_t last);
		key_t cand;
		logic stop;
		cand      = first;
		exp_found = 1'b0;
		exp_key   = '0;
		stop      = 1'b0;
		while (!stop) begin
			make_keystream(cand, msg_len);
			if (text_printable(msg_len)) begin
				exp_found = 1'b1;
				exp_key   = cand;
				stop      = 1'b1;
			end else if (cand >= last) begin
				stop = 1'b1;
			end else begin
				cand = cand + 24'd1;
			end
		end
	endtask

	task automatic new_message();
		msg_len = 8 + $unsigned($random(seed)) % 33;
		secret  = {1'b0, 23'($random(seed))};
		if (secret < 24'd16)
			secret = secret + 24'd16;
		make_keystream(secret, msg_len);
		for (int k = 1; k <= msg_len; k++) begin
			msg[k] = 8'(8'h20 + $unsigned($random(seed)) % 95);
			ct[k]  = msg[k] ^ ks[k];
		end
		bus_write(`CT_BASE, msg_len);
		for (int k = 1; k <= msg_len; k++)
			bus_write(`CT_BASE + 12'(4 * k), ct[k]);
	endtask

	task automatic run_search(input key_t first, input key_t last, input string tag);
		logic [31:0] data;
		model_search(first, last);
		bus_write(`REG_FIRST_KEY, first);
		bus_write(`REG_LAST_KEY, last);
		bus_write(`REG_CTRL, 32'h1);
		bus_read(`REG_STATUS, data);
		while (!data[1])
			bus_read(`REG_STATUS, data);
		check_eq(data, {29'd0, exp_found, 2'b10}, {tag, " final status"});
		if (exp_found) begin
			bus_read(`REG_FOUND_KEY, data);
			check_eq(data, {8'd0, exp_key}, {tag, " found key"});
			make_keystream(exp_key, msg_len);
			bus_read(`PT_BASE, data);
			check_eq(data, msg_len, {tag, " plaintext length"});
			for (int k = 1; k <= msg_len; k++) begin
				bus_read(`PT_BASE + 12'(4 * k), data);
				check_eq(data, {24'd0, ct[k] ^ ks[k]}, {tag, " plaintext byte"});
			end
		end
	endtask

	initial begin
		logic [31:0] data;
		key_t        k0, k1;
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_sel   = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		bus_read(`REG_STATUS, data);
		check_eq(data, 32'd0, "status after reset");
		k0 = key_t'($random(seed));
		k1 = key_t'($random(seed));
		bus_write(`REG_FIRST_KEY, k0);
		bus_write(`REG_LAST_KEY, k1);
		bus_read(`REG_FIRST_KEY, data);
		check_eq(data, {8'd0, k0}, "first key readback");
		bus_read(`REG_LAST_KEY, data);
		check_eq(data, {8'd0, k1}, "last key readback");

		// the range opens a few keys below the secret key
		repeat (N_SUCCESS) begin
			new_message();
			run_search(secret - 24'($unsigned($random(seed)) % 6), secret + 24'd2, "search");
		end

		// move the window above the secret key until the model accepts nothing in it
		k0 = secret + 24'd3;
		model_search(k0, k0 + 24'd5);
		while (exp_found) begin
			k0 = k0 + 24'd6;
			model_search(k0, k0 + 24'd5);
		end
		run_search(k0, k0 + 24'd5, "exhaustion");

		// no key can finish in 400 cycles, so the abort always hits a running search
		new_message();
		bus_write(`REG_FIRST_KEY, secret + 24'd100);
		bus_write(`REG_LAST_KEY, secret + 24'd5000);
		bus_write(`REG_CTRL, 32'h1);
		repeat (400) @(posedge clk);
		bus_read(`REG_STATUS, data);
		check_eq(data, 32'h1, "status while searching");
		bus_write(`REG_CTRL, 32'h2);
		bus_read(`REG_STATUS, data);
		check_eq(data, 32'h2, "status after abort");
		run_search(secret - 24'd3, secret + 24'd2, "search after abort");

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* arc4_crack.f */
+incdir+.
arc4_crack_pkg.sv
byte_ram.sv
arc4_core.sv
pt_check.sv
crack_ctrl.sv
crack_regs.sv
arc4_crack_top.sv
arc4_crack_properties.sv
arc4_crack_tb.sv
